// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_pipeline_cpu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

	// Next program counter source, chosen in decode.
	typedef enum logic [1:0] {
		PC_SEQ,		// Fall through to PC+4.
		PC_JUMP,	// Pseudo-direct jump target.
		PC_BRANCH	// PC-relative branch target.
	} pc_sel_e;

	// Second ALU operand.
	typedef enum logic {
		SRC_REG,	// Value of rt.
		SRC_IMM		// Sign-extended immediate.
	} alu_src_e;

	// Register written back.
	typedef enum logic {
		DST_RT,		// I-type destination.
		DST_RD		// R-type destination.
	} reg_dst_e;

	// Writeback data source.
	typedef enum logic {
		WB_MEM,		// Load data.
		WB_ALU		// ALU result.
	} wb_src_e;

endpackage

// ==== cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	// Machine word and register file geometry.
	localparam int unsigned XLEN       = 32;
	localparam int unsigned REG_ADDR_W = 5;
	localparam int unsigned NUM_REGS   = 1 << REG_ADDR_W;

	// Instruction field widths and positions.
	localparam int unsigned OPC_W  = 6;
	localparam int unsigned IMM_W  = 16;
	localparam int unsigned JIDX_W = 26;
	localparam int unsigned OP_LSB = 26;
	localparam int unsigned RS_LSB = 21;
	localparam int unsigned RT_LSB = 16;
	localparam int unsigned RD_LSB = 11;

	// All-zero word decodes as an R-type with no valid funct.
	localparam logic [XLEN-1:0] INSTR_NOP = '0;

	typedef enum logic [OPC_W-1:0] {
		R_TYPE = 6'd0,	// Arithmetic and logic, funct selects.
		J      = 6'd2,
		BEQ    = 6'd4,
		ADDI   = 6'd8,
		LW     = 6'd35,
		SW     = 6'd43
	} opcode_e;

	typedef enum logic [OPC_W-1:0] {
		F_MUL = 6'd24,
		F_ADD = 6'd32,
		F_SUB = 6'd34,
		F_AND = 6'd36,
		F_OR  = 6'd37
	} funct_e;

	// MUL keeps only the low word of the product.
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_MUL,
		ALU_AND,
		ALU_OR
	} alu_op_e;

endpackage

// ==== decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
	input  logic                               clk_i,
	input  logic                               rst_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]       instr_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]       pc_plus4_i,
	input  logic                               wb_we_i,
	input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] wb_addr_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]       wb_data_i,
	output cpu_ctrl_pkg::pc_sel_e              pc_sel_o,
	output logic [cpu_isa_pkg::XLEN-1:0]       jump_target_o,
	output logic [cpu_isa_pkg::XLEN-1:0]       branch_target_o,
	output cpu_isa_pkg::alu_op_e               ex_alu_op_o,
	output cpu_ctrl_pkg::alu_src_e             ex_alu_src_o,
	output cpu_ctrl_pkg::reg_dst_e             ex_reg_dst_o,
	output logic                               ex_mem_cs_o,
	output logic                               ex_mem_we_o,
	output logic                               ex_reg_we_o,
	output cpu_ctrl_pkg::wb_src_e              ex_wb_src_o,
	output logic [cpu_isa_pkg::XLEN-1:0]       ex_rs_val_o,
	output logic [cpu_isa_pkg::XLEN-1:0]       ex_rt_val_o,
	output logic [cpu_isa_pkg::XLEN-1:0]       ex_imm_o,
	output logic [cpu_isa_pkg::REG_ADDR_W-1:0] ex_rt_o,
	output logic [cpu_isa_pkg::REG_ADDR_W-1:0] ex_rd_o
);

	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	logic [XLEN-1:0]       regs [NUM_REGS];
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0]       rs_val;
	logic [XLEN-1:0]       rt_val;
	logic [XLEN-1:0]       imm;
	logic                  is_equal;
	alu_op_e               alu_op;
	alu_src_e              alu_src;
	reg_dst_e              reg_dst;
	logic                  mem_cs;
	logic                  mem_we;
	logic                  reg_we;
	wb_src_e               wb_src;

	assign rs  = instr_i[RS_LSB +: REG_ADDR_W];
	assign rt  = instr_i[RT_LSB +: REG_ADDR_W];
	assign rd  = instr_i[RD_LSB +: REG_ADDR_W];
	assign imm = {{(XLEN-IMM_W){instr_i[IMM_W-1]}}, instr_i[IMM_W-1:0]};

	// Same-cycle writeback is passed straight to the readers.
	assign rs_val = (wb_we_i && wb_addr_i == rs && rs != '0) ? wb_data_i : regs[rs];
	assign rt_val = (wb_we_i && wb_addr_i == rt && rt != '0) ? wb_data_i : regs[rt];
	assign is_equal = (rs_val == rt_val);

	assign branch_target_o = pc_plus4_i + {imm[XLEN-3:0], 2'b00};
	assign jump_target_o   = {pc_plus4_i[XLEN-1:XLEN-4], instr_i[JIDX_W-1:0], 2'b00};

	general_control u_ctrl (
		.op_i       (opcode_e'(instr_i[OP_LSB +: OPC_W])),
		.func_i     (funct_e'(instr_i[OPC_W-1:0])),
		.is_equal_i (is_equal),
		.pc_sel_o   (pc_sel_o),
		.alu_op_o   (alu_op),
		.alu_src_o  (alu_src),
		.reg_dst_o  (reg_dst),
		.mem_cs_o   (mem_cs),
		.mem_we_o   (mem_we),
		.reg_we_o   (reg_we),
		.wb_src_o   (wb_src)
	);

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wb_we_i && wb_addr_i != '0)	// Register 0 stays zero.
			regs[wb_addr_i] <= wb_data_i;
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			ex_alu_op_o  <= ALU_ADD;
			ex_alu_src_o <= SRC_REG;
			ex_reg_dst_o <= DST_RT;
			ex_mem_cs_o  <= 1'b0;
			ex_mem_we_o  <= 1'b0;
			ex_reg_we_o  <= 1'b0;
			ex_wb_src_o  <= WB_ALU;
		end
		else
		begin
			ex_alu_op_o  <= alu_op;
			ex_alu_src_o <= alu_src;
			ex_reg_dst_o <= reg_dst;
			ex_mem_cs_o  <= mem_cs;
			ex_mem_we_o  <= mem_we;
			ex_reg_we_o  <= reg_we;
			ex_wb_src_o  <= wb_src;
		end
	end

	always_ff @(posedge clk_i)
	begin
		ex_rs_val_o <= rs_val;
		ex_rt_val_o <= rt_val;
		ex_imm_o    <= imm;
		ex_rt_o     <= rt;
		ex_rd_o     <= rd;
	end

	// Register 0 keeps reading zero whatever the writeback targets.
	assert property (@(posedge clk_i) disable iff (rst_i) regs[0] == '0);

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
	input  logic                               clk_i,
	input  logic                               rst_i,
	input  cpu_isa_pkg::alu_op_e               ex_alu_op_i,
	input  cpu_ctrl_pkg::alu_src_e             ex_alu_src_i,
	input  cpu_ctrl_pkg::reg_dst_e             ex_reg_dst_i,
	input  logic                               ex_mem_cs_i,
	input  logic                               ex_mem_we_i,
	input  logic                               ex_reg_we_i,
	input  cpu_ctrl_pkg::wb_src_e              ex_wb_src_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]       ex_rs_val_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]       ex_rt_val_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]       ex_imm_i,
	input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] ex_rt_i,
	input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] ex_rd_i,
	output logic [cpu_isa_pkg::XLEN-1:0]       mem_alu_result_o,
	output logic [cpu_isa_pkg::XLEN-1:0]       mem_store_data_o,
	output logic [cpu_isa_pkg::REG_ADDR_W-1:0] mem_dst_o,
	output logic                               mem_cs_o,
	output logic                               mem_we_o,
	output logic                               mem_reg_we_o,
	output cpu_ctrl_pkg::wb_src_e              mem_wb_src_o
);

	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	logic [XLEN-1:0]       op_b;
	logic [XLEN-1:0]       alu_result;
	logic [REG_ADDR_W-1:0] dst;

	assign op_b = (ex_alu_src_i == SRC_IMM) ? ex_imm_i : ex_rt_val_i;
	assign dst  = (ex_reg_dst_i == DST_RD) ? ex_rd_i : ex_rt_i;

	always_comb
	begin
		case (ex_alu_op_i)
			ALU_ADD: alu_result = ex_rs_val_i + op_b;
			ALU_SUB: alu_result = ex_rs_val_i - op_b;
			ALU_MUL: alu_result = ex_rs_val_i * op_b;	// Low word only.
			ALU_AND: alu_result = ex_rs_val_i & op_b;
			ALU_OR:  alu_result = ex_rs_val_i | op_b;
			default: alu_result = '0;
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			mem_cs_o     <= 1'b0;
			mem_we_o     <= 1'b0;
			mem_reg_we_o <= 1'b0;
			mem_wb_src_o <= WB_ALU;
		end
		else
		begin
			mem_cs_o     <= ex_mem_cs_i;
			mem_we_o     <= ex_mem_we_i;
			mem_reg_we_o <= ex_reg_we_i;
			mem_wb_src_o <= ex_wb_src_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		mem_alu_result_o <= alu_result;
		mem_store_data_o <= ex_rt_val_i;	// Store data comes from rt.
		mem_dst_o        <= dst;
	end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
	input  logic                           clk_i,
	input  logic                           rst_i,
	input  cpu_ctrl_pkg::pc_sel_e          pc_sel_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]   jump_target_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]   branch_target_i,
	output logic [cpu_isa_pkg::XLEN-1:0]   imem_addr_o,
	input  logic [cpu_isa_pkg::XLEN-1:0]   imem_data_i,
	output logic [cpu_isa_pkg::XLEN-1:0]   instr_o,
	output logic [cpu_isa_pkg::XLEN-1:0]   pc_plus4_o
);

	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] next_pc;

	assign pc_plus4    = pc + 32'd4;
	assign imem_addr_o = pc;	// Combinational fetch address.

	always_comb
	begin
		case (pc_sel_i)
			PC_JUMP:   next_pc = jump_target_i;
			PC_BRANCH: next_pc = branch_target_i;
			default:   next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			pc      <= '0;
			instr_o <= INSTR_NOP;	// Pipeline starts empty.
		end
		else
		begin
			pc      <= next_pc;
			instr_o <= imem_data_i;
		end
	end

	always_ff @(posedge clk_i)
		pc_plus4_o <= pc_plus4;

	assert property (@(posedge clk_i) disable iff (rst_i) pc[1:0] == 2'b00);

endmodule

// ==== files.f ====
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
general_control.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
pipeline_cpu.sv
tb_pipeline_cpu.sv

// ==== general_control.sv ====
`timescale 1ns/10ps

module general_control (
	input  cpu_isa_pkg::opcode_e    op_i,
	input  cpu_isa_pkg::funct_e     func_i,
	input  logic                    is_equal_i,
	output cpu_ctrl_pkg::pc_sel_e   pc_sel_o,
	output cpu_isa_pkg::alu_op_e    alu_op_o,
	output cpu_ctrl_pkg::alu_src_e  alu_src_o,
	output cpu_ctrl_pkg::reg_dst_e  reg_dst_o,
	output logic                    mem_cs_o,
	output logic                    mem_we_o,
	output logic                    reg_we_o,
	output cpu_ctrl_pkg::wb_src_e   wb_src_o
);

	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	always_comb
	begin
		// Anything not listed below behaves as a nop.
		pc_sel_o  = PC_SEQ;
		alu_op_o  = ALU_ADD;
		alu_src_o = SRC_REG;
		reg_dst_o = DST_RT;
		mem_cs_o  = 1'b0;
		mem_we_o  = 1'b0;
		reg_we_o  = 1'b0;
		wb_src_o  = WB_ALU;

		case (op_i)
			R_TYPE:
			begin
				reg_dst_o = DST_RD;	// Result goes to rd.
				case (func_i)
					F_ADD:
					begin
						alu_op_o = ALU_ADD;
						reg_we_o = 1'b1;
					end
					F_SUB:
					begin
						alu_op_o = ALU_SUB;
						reg_we_o = 1'b1;
					end
					F_MUL:
					begin
						alu_op_o = ALU_MUL;
						reg_we_o = 1'b1;
					end
					F_AND:
					begin
						alu_op_o = ALU_AND;
						reg_we_o = 1'b1;
					end
					F_OR:
					begin
						alu_op_o = ALU_OR;
						reg_we_o = 1'b1;
					end
					default:
						reg_we_o = 1'b0;	// Unknown funct.
				endcase
			end

			ADDI:
			begin
				alu_src_o = SRC_IMM;
				reg_we_o  = 1'b1;
			end

			LW:
			begin
				alu_src_o = SRC_IMM;	// Base plus offset.
				mem_cs_o  = 1'b1;
				reg_we_o  = 1'b1;
				wb_src_o  = WB_MEM;
			end

			SW:
			begin
				alu_src_o = SRC_IMM;
				mem_cs_o  = 1'b1;
				mem_we_o  = 1'b1;
			end

			J:
				pc_sel_o = PC_JUMP;

			BEQ:
				pc_sel_o = is_equal_i ? PC_BRANCH : PC_SEQ;

			default:
				pc_sel_o = PC_SEQ;
		endcase

		// A store always enables the data memory.
		assert (!mem_we_o || mem_cs_o);
	end

endmodule

// ==== memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage (
	input  logic                               clk_i,
	input  logic                               rst_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]       mem_alu_result_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]       mem_store_data_i,
	input  logic [cpu_isa_pkg::REG_ADDR_W-1:0] mem_dst_i,
	input  logic                               mem_cs_i,
	input  logic                               mem_we_i,
	input  logic                               mem_reg_we_i,
	input  cpu_ctrl_pkg::wb_src_e              mem_wb_src_i,
	output logic                               dmem_cs_o,
	output logic                               dmem_we_o,
	output logic [cpu_isa_pkg::XLEN-1:0]       dmem_addr_o,
	output logic [cpu_isa_pkg::XLEN-1:0]       dmem_wdata_o,
	input  logic [cpu_isa_pkg::XLEN-1:0]       dmem_rdata_i,
	output logic                               wb_we_o,
	output logic [cpu_isa_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [cpu_isa_pkg::XLEN-1:0]       wb_data_o
);

	import cpu_ctrl_pkg::*;

	// Data port is driven straight from EX/MEM.
	assign dmem_cs_o    = mem_cs_i;
	assign dmem_we_o    = mem_we_i;
	assign dmem_addr_o  = mem_alu_result_i;
	assign dmem_wdata_o = mem_store_data_i;

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			wb_we_o <= 1'b0;
		else
			wb_we_o <= mem_reg_we_i;
	end

	always_ff @(posedge clk_i)
	begin
		wb_addr_o <= mem_dst_i;
		wb_data_o <= (mem_wb_src_i == WB_MEM) ? dmem_rdata_i : mem_alu_result_i;
	end

	assert property (@(posedge clk_i) disable iff (rst_i) dmem_we_o |-> dmem_cs_o);

endmodule

// ==== pipeline_cpu.sv ====
`timescale 1ns/10ps

module pipeline_cpu (
	input  logic                         clk_i,
	input  logic                         rst_i,
	output logic [cpu_isa_pkg::XLEN-1:0] imem_addr_o,
	input  logic [cpu_isa_pkg::XLEN-1:0] imem_data_i,
	output logic                         dmem_cs_o,
	output logic                         dmem_we_o,
	output logic [cpu_isa_pkg::XLEN-1:0] dmem_addr_o,
	output logic [cpu_isa_pkg::XLEN-1:0] dmem_wdata_o,
	input  logic [cpu_isa_pkg::XLEN-1:0] dmem_rdata_i
);

	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	// IF/ID and redirect.
	logic [XLEN-1:0]       id_instr;
	logic [XLEN-1:0]       id_pc_plus4;
	pc_sel_e               pc_sel;
	logic [XLEN-1:0]       jump_target;
	logic [XLEN-1:0]       branch_target;

	// ID/EX.
	alu_op_e               ex_alu_op;
	alu_src_e              ex_alu_src;
	reg_dst_e              ex_reg_dst;
	logic                  ex_mem_cs;
	logic                  ex_mem_we;
	logic                  ex_reg_we;
	wb_src_e               ex_wb_src;
	logic [XLEN-1:0]       ex_rs_val;
	logic [XLEN-1:0]       ex_rt_val;
	logic [XLEN-1:0]       ex_imm;
	logic [REG_ADDR_W-1:0] ex_rt;
	logic [REG_ADDR_W-1:0] ex_rd;

	// EX/MEM.
	logic [XLEN-1:0]       mem_alu_result;
	logic [XLEN-1:0]       mem_store_data;
	logic [REG_ADDR_W-1:0] mem_dst;
	logic                  mem_cs;
	logic                  mem_we;
	logic                  mem_reg_we;
	wb_src_e               mem_wb_src;

	// MEM/WB back to the register file.
	logic                  wb_we;
	logic [REG_ADDR_W-1:0] wb_addr;
	logic [XLEN-1:0]       wb_data;

	fetch_stage u_fetch (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.pc_sel_i        (pc_sel),
		.jump_target_i   (jump_target),
		.branch_target_i (branch_target),
		.imem_addr_o     (imem_addr_o),
		.imem_data_i     (imem_data_i),
		.instr_o         (id_instr),
		.pc_plus4_o      (id_pc_plus4)
	);

	decode_stage u_decode (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.instr_i         (id_instr),
		.pc_plus4_i      (id_pc_plus4),
		.wb_we_i         (wb_we),
		.wb_addr_i       (wb_addr),
		.wb_data_i       (wb_data),
		.pc_sel_o        (pc_sel),
		.jump_target_o   (jump_target),
		.branch_target_o (branch_target),
		.ex_alu_op_o     (ex_alu_op),
		.ex_alu_src_o    (ex_alu_src),
		.ex_reg_dst_o    (ex_reg_dst),
		.ex_mem_cs_o     (ex_mem_cs),
		.ex_mem_we_o     (ex_mem_we),
		.ex_reg_we_o     (ex_reg_we),
		.ex_wb_src_o     (ex_wb_src),
		.ex_rs_val_o     (ex_rs_val),
		.ex_rt_val_o     (ex_rt_val),
		.ex_imm_o        (ex_imm),
		.ex_rt_o         (ex_rt),
		.ex_rd_o         (ex_rd)
	);

	execute_stage u_execute (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.ex_alu_op_i      (ex_alu_op),
		.ex_alu_src_i     (ex_alu_src),
		.ex_reg_dst_i     (ex_reg_dst),
		.ex_mem_cs_i      (ex_mem_cs),
		.ex_mem_we_i      (ex_mem_we),
		.ex_reg_we_i      (ex_reg_we),
		.ex_wb_src_i      (ex_wb_src),
		.ex_rs_val_i      (ex_rs_val),
		.ex_rt_val_i      (ex_rt_val),
		.ex_imm_i         (ex_imm),
		.ex_rt_i          (ex_rt),
		.ex_rd_i          (ex_rd),
		.mem_alu_result_o (mem_alu_result),
		.mem_store_data_o (mem_store_data),
		.mem_dst_o        (mem_dst),
		.mem_cs_o         (mem_cs),
		.mem_we_o         (mem_we),
		.mem_reg_we_o     (mem_reg_we),
		.mem_wb_src_o     (mem_wb_src)
	);

	memory_stage u_memory (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.mem_alu_result_i (mem_alu_result),
		.mem_store_data_i (mem_store_data),
		.mem_dst_i        (mem_dst),
		.mem_cs_i         (mem_cs),
		.mem_we_i         (mem_we),
		.mem_reg_we_i     (mem_reg_we),
		.mem_wb_src_i     (mem_wb_src),
		.dmem_cs_o        (dmem_cs_o),
		.dmem_we_o        (dmem_we_o),
		.dmem_addr_o      (dmem_addr_o),
		.dmem_wdata_o     (dmem_wdata_o),
		.dmem_rdata_i     (dmem_rdata_i),
		.wb_we_o          (wb_we),
		.wb_addr_o        (wb_addr),
		.wb_data_o        (wb_data)
	);

endmodule

// ==== tb_pipeline_cpu.sv ====
`timescale 1ns/10ps

module tb_pipeline_cpu;

	import cpu_isa_pkg::*;

	localparam int NUM_CASES   = 11;
	localparam int NUM_TESTS   = NUM_CASES + 3;
	localparam int PROG_LEN    = 14;	// Longest program below.
	localparam int CYCLE_LIMIT = NUM_TESTS * (PROG_LEN + 20);
	localparam logic [15:0] STORE_ADDR = 16'h00F0;

	typedef struct packed {
		opcode_e         op;
		funct_e          fn;
		logic [15:0]     a;
		logic [15:0]     b;
		logic [XLEN-1:0] exp_data;
		logic [XLEN-1:0] exp_addr;
	} alu_case_t;

	logic            clk;
	logic            rst;
	logic [XLEN-1:0] imem_addr;
	logic [XLEN-1:0] imem_data;
	logic            dmem_cs;
	logic            dmem_we;
	logic [XLEN-1:0] dmem_addr;
	logic [XLEN-1:0] dmem_wdata;
	logic [XLEN-1:0] dmem_rdata;

	logic [XLEN-1:0] instr_mem [64];
	logic [XLEN-1:0] data_mem [64];
	alu_case_t       cases [NUM_CASES];
	funct_e          rand_fn [5] = '{F_ADD, F_SUB, F_AND, F_OR, F_MUL};
	logic [XLEN-1:0] exp_addr_q [$];
	logic [XLEN-1:0] exp_data_q [$];
	logic [31:0]     rnd;
	integer          seed = 32'h3088_d619;
	int              prog_len = 0;
	int              test_errors = 0;
	int              pass_count = 0;
	int              fail_count = 0;
	int              cycles = 0;

	pipeline_cpu UUT (
		.clk_i        (clk),
		.rst_i        (rst),
		.imem_addr_o  (imem_addr),
		.imem_data_i  (imem_data),
		.dmem_cs_o    (dmem_cs),
		.dmem_we_o    (dmem_we),
		.dmem_addr_o  (dmem_addr),
		.dmem_wdata_o (dmem_wdata),
		.dmem_rdata_i (dmem_rdata)
	);

	// Both memories answer in the same cycle.
	assign imem_data  = instr_mem[imem_addr[7:2]];
	assign dmem_rdata = data_mem[dmem_addr[7:2]];

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		if (dmem_cs && dmem_we)
			data_mem[dmem_addr[7:2]] <= dmem_wdata;	// Store lands on this edge.
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: the tests did not finish within %0d clock cycles.", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [XLEN-1:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// Expected result from the instruction set rules.
	function automatic logic [XLEN-1:0] alu_rule(input opcode_e op, input funct_e fn,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		if (op == ADDI)
			return a + b;
		case (fn)
			F_SUB:   return a - b;
			F_MUL:   return a * b;	// Low word of the product.
			F_AND:   return a & b;
			F_OR:    return a | b;
			default: return a + b;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] enc_r(input funct_e fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {R_TYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [XLEN-1:0] enc_i(input opcode_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [XLEN-1:0] enc_j(input logic [25:0] idx);
		return {J, idx};
	endfunction

	task automatic check_word(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic emit(input logic [XLEN-1:0] word);
		instr_mem[prog_len] = word;
		prog_len++;
	endtask

	task automatic expect_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	task automatic clear_memories;
		for (int i = 0; i < 64; i++)
		begin
			instr_mem[i] = INSTR_NOP;
			data_mem[i] <= 32'hD0D0_0000 | (i << 2);	// Differs per word.
		end
	endtask

	task automatic set_case(input int idx, input opcode_e op, input funct_e fn,
		input logic [15:0] a, input logic [15:0] b);
		cases[idx].op       = op;
		cases[idx].fn       = fn;
		cases[idx].a        = a;
		cases[idx].b        = b;
		cases[idx].exp_data = alu_rule(op, fn, sext16(a), sext16(b));
		cases[idx].exp_addr = sext16(STORE_ADDR);
	endtask

	// Reset starts here so nothing in flight writes the fresh memories.
	task automatic start_test;
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		clear_memories();
		exp_addr_q.delete();
		exp_data_q.delete();
		prog_len    = 0;
		test_errors = 0;
	endtask

	task automatic run_and_check(input string name);
		repeat (9)
		begin
			@(negedge clk);
			check_flag("dmem_cs_o", dmem_cs, 1'b0);
			check_flag("dmem_we_o", dmem_we, 1'b0);
			check_word("imem_addr_o", imem_addr, '0);
		end
		rst = 1'b0;
		@(negedge clk);
		check_flag("dmem_cs_o", dmem_cs, 1'b0);
		check_flag("dmem_we_o", dmem_we, 1'b0);
		while (exp_addr_q.size() > 0)
		begin
			@(negedge clk);
			if (dmem_cs && dmem_we)
			begin
				check_word("dmem_addr_o", dmem_addr, exp_addr_q.pop_front());
				check_word("dmem_wdata_o", dmem_wdata, exp_data_q.pop_front());
			end
		end
		if (test_errors == 0)
		begin
			pass_count++;
			$display("test %s passed", name);
		end
		else
		begin
			fail_count++;
			$display("test %s failed with %0d errors", name, test_errors);
		end
	endtask

	task automatic build_alu_program(input alu_case_t c);
		emit(enc_i(ADDI, 5'd0, 5'd1, c.a));
		emit(enc_i(ADDI, 5'd0, 5'd2, c.b));
		emit(INSTR_NOP);
		emit(INSTR_NOP);
		if (c.op == ADDI)
			emit(enc_i(ADDI, 5'd1, 5'd3, c.b));
		else
			emit(enc_r(c.fn, 5'd1, 5'd2, 5'd3));
		emit(INSTR_NOP);
		emit(INSTR_NOP);
		emit(enc_i(SW, 5'd0, 5'd3, STORE_ADDR));
		expect_store(c.exp_addr, c.exp_data);
	endtask

	task automatic run_load_store;
		start_test();
		emit(enc_i(ADDI, 5'd0, 5'd1, 16'hC001));
		emit(INSTR_NOP);
		emit(INSTR_NOP);
		emit(enc_i(SW, 5'd0, 5'd1, 16'h0040));
		emit(enc_i(LW, 5'd0, 5'd2, 16'h0040));	// Reads back the store just above.
		emit(INSTR_NOP);
		emit(INSTR_NOP);
		emit(enc_r(F_ADD, 5'd2, 5'd2, 5'd3));
		emit(INSTR_NOP);
		emit(INSTR_NOP);
		emit(enc_i(SW, 5'd0, 5'd3, 16'h0044));
		expect_store(32'h0000_0040, 32'hFFFF_C001);
		expect_store(32'h0000_0044, 32'hFFFF_8002);	// Twice the loaded word.
		run_and_check("load_store");
	endtask

	task automatic run_branches;
		start_test();
		emit(enc_i(ADDI, 5'd0, 5'd1, 16'd5));
		emit(enc_i(ADDI, 5'd0, 5'd2, 16'd5));
		emit(enc_i(ADDI, 5'd0, 5'd4, 16'd7));
		emit(INSTR_NOP);
		emit(enc_i(BEQ, 5'd1, 5'd2, 16'd3));	// Taken, lands on word 8.
		emit(enc_i(SW, 5'd0, 5'd1, 16'h0080));	// Delay slot.
		emit(enc_i(SW, 5'd0, 5'd4, 16'h0084));
		emit(enc_i(SW, 5'd0, 5'd4, 16'h0088));
		emit(enc_i(BEQ, 5'd1, 5'd4, 16'd2));	// Not taken.
		emit(enc_i(SW, 5'd0, 5'd2, 16'h008C));
		emit(enc_j(26'd13));
		emit(enc_i(SW, 5'd0, 5'd4, 16'h0090));	// Delay slot of the jump.
		emit(enc_i(SW, 5'd0, 5'd1, 16'h0094));
		emit(enc_i(SW, 5'd0, 5'd4, 16'h0098));
		expect_store(32'h0000_0080, 32'd5);
		expect_store(32'h0000_008C, 32'd5);
		expect_store(32'h0000_0090, 32'd7);
		expect_store(32'h0000_0098, 32'd7);
		run_and_check("branches");
	endtask

	task automatic run_unknown;
		start_test();
		emit(enc_i(ADDI, 5'd0, 5'd1, 16'h0011));
		emit(enc_i(ADDI, 5'd0, 5'd2, 16'h0022));
		emit(INSTR_NOP);
		emit(enc_i(SW, 5'd0, 5'd1, 16'h00A0));
		emit({6'd13, 5'd2, 5'd1, 16'hFFFF});	// Unsupported immediate op on r1.
		emit({6'd0, 5'd1, 5'd1, 5'd2, 5'd0, 6'd39});	// Unsupported funct on r2.
		emit({6'd41, 5'd0, 5'd1, 16'h00A8});	// Unsupported halfword store.
		emit(INSTR_NOP);
		emit(enc_i(SW, 5'd0, 5'd1, 16'h00A4));
		emit(enc_i(SW, 5'd0, 5'd2, 16'h00AC));
		expect_store(32'h0000_00A0, 32'h0000_0011);
		expect_store(32'h0000_00A4, 32'h0000_0011);
		expect_store(32'h0000_00AC, 32'h0000_0022);
		run_and_check("unknown_op");
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		clear_memories();
		set_case(0, R_TYPE, F_ADD, 16'd1234, 16'hFFF6);
		set_case(1, R_TYPE, F_SUB, 16'd50, 16'd75);
		set_case(2, R_TYPE, F_MUL, 16'hFED4, 16'd25000);
		set_case(3, R_TYPE, F_AND, 16'hF0F0, 16'h3C3C);
		set_case(4, R_TYPE, F_OR, 16'h0A0A, 16'h8001);
		set_case(5, ADDI, F_ADD, 16'd20, 16'hFF9C);	// Negative immediate.
		for (int i = 6; i < NUM_CASES; i++)
		begin
			rnd = $random(seed);
			set_case(i, R_TYPE, rand_fn[i-6], rnd[15:0], rnd[31:16]);
		end

		for (int i = 0; i < NUM_CASES; i++)
		begin
			start_test();
			build_alu_program(cases[i]);
			run_and_check($sformatf("alu_%0d", i));
		end
		run_load_store();
		run_branches();
		run_unknown();

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
